/* Makefile */
# Verilator build and run for the snake game core

SIM       = verilator
TOP       = snake_game_tb
FILELIST  = snake_game_top.f
FLAGS     = --binary --timing --assert -Wno-fatal
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST))
BINARY  = $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@grep -q "^Everything OK$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* snake_game_top.f */
source/snake_pkg.sv
source/turn_input.sv
source/snake_body.sv
source/game_control.sv
source/snake_game_top.sv
verification/snake_game_checker.sv
verification/snake_game_tb.sv

/* source/game_control.sv */
// Game FSM, heading and collision check
`timescale 1ns/1ps
`default_nettype none

module game_control
    import snake_pkg::*;
(
    input  wire             clock_25,
    input  wire             reset,
    input  wire             game_tick,
    input  wire             press,
    input  wire turn_t      pending_turn,
    input  wire position_t  head,
    input  wire body_t      body,
    output heading_t        heading,
    output logic            restart,
    output logic            move,
    output logic            playing,
    output logic            game_over
);

    game_state_t              state;
    game_state_t              state_next;
    heading_t                 move_heading;  // Direction of the last step
    logic [BODY_SEGMENTS-1:0] body_hit;
    logic                     border_hit;
    logic                     collision;

    // Quarter turn, y grows downward
    function automatic heading_t rotate(heading_t dir, turn_t turn);
        heading_t rotated;
        rotated = dir;
        if (turn.clockwise) begin
            case (dir)
                HEAD_RIGHT: rotated = HEAD_DOWN;
                HEAD_DOWN:  rotated = HEAD_LEFT;
                HEAD_LEFT:  rotated = HEAD_UP;
                default:    rotated = HEAD_RIGHT;
            endcase
        end else if (turn.counter_clockwise) begin
            case (dir)
                HEAD_RIGHT: rotated = HEAD_UP;
                HEAD_UP:    rotated = HEAD_LEFT;
                HEAD_LEFT:  rotated = HEAD_DOWN;
                default:    rotated = HEAD_RIGHT;
            endcase
        end
        return rotated;
    endfunction

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            state <= RESTART;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            RESTART:   state_next = IDLE;
            IDLE:      if (press) state_next = WAIT_TICK;
            WAIT_TICK: if (game_tick) state_next = MOVING;
            MOVING:    state_next = MOVE_DONE;
            MOVE_DONE: state_next = collision ? GAME_OVER : WAIT_TICK;
            GAME_OVER: if (press) state_next = RESTART;
            default:   state_next = RESTART;
        endcase
    end

    assign restart   = (state == RESTART);
    assign move      = (state == MOVING);
    assign playing   = (state == WAIT_TICK) || (state == MOVING) || (state == MOVE_DONE);
    assign game_over = (state == GAME_OVER);

    // Heading of the snake as laid out, so only the last press counts
    always_comb begin
        move_heading = heading;
        if (head.y == body[0].y) begin
            if (head.x > body[0].x)
                move_heading = HEAD_RIGHT;
            else if (head.x < body[0].x)
                move_heading = HEAD_LEFT;
        end else if (head.x == body[0].x) begin
            move_heading = (head.y < body[0].y) ? HEAD_UP : HEAD_DOWN;
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            heading <= HEAD_RIGHT;
        else if (restart)
            heading <= HEAD_RIGHT;
        else if (pending_turn != '0)
            heading <= rotate(move_heading, pending_turn);
    end

    always_comb begin
        for (int i = 0; i < BODY_SEGMENTS; i++)
            body_hit[i] = (head == body[i]);  // Head on its own body
    end

    // Border cell with the heading pointing off the board
    always_comb begin
        case (heading)
            HEAD_UP:    border_hit = (head.y == '0);
            HEAD_DOWN:  border_hit = (head.y == coord_t'(GRID_HEIGHT - 1));
            HEAD_LEFT:  border_hit = (head.x == '0);
            default:    border_hit = (head.x == coord_t'(GRID_WIDTH - 1));
        endcase
    end

    assign collision = (|body_hit) | border_hit;

endmodule

`default_nettype wire

/* source/snake_body.sv */
// Snake head and body storage
`timescale 1ns/1ps
`default_nettype none

module snake_body
    import snake_pkg::*;
(
    input  wire            clock_25,
    input  wire            reset,
    input  wire            restart,
    input  wire            move,
    input  wire heading_t  heading,
    output position_t      head,
    output body_t          body
);

    // Straight body to the left of the start head
    function automatic body_t start_body();
        body_t segments;
        for (int i = 0; i < BODY_SEGMENTS; i++) begin
            segments[i].x = START_HEAD_X - coord_t'(i + 1);
            segments[i].y = START_HEAD_Y;
        end
        return segments;
    endfunction

    // One cell along dir, a coordinate at the edge of the board is held
    function automatic position_t step_head(position_t pos, heading_t dir);
        position_t stepped;
        stepped = pos;
        case (dir)
            HEAD_UP: begin
                if (pos.y != '0)
                    stepped.y = pos.y - 1'b1;
            end
            HEAD_DOWN: begin
                if (pos.y != coord_t'(GRID_HEIGHT - 1))
                    stepped.y = pos.y + 1'b1;
            end
            HEAD_LEFT: begin
                if (pos.x != '0)
                    stepped.x = pos.x - 1'b1;
            end
            HEAD_RIGHT: begin
                if (pos.x != coord_t'(GRID_WIDTH - 1))
                    stepped.x = pos.x + 1'b1;
            end
            default: stepped = pos;
        endcase
        return stepped;
    endfunction

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head.x <= START_HEAD_X;
            head.y <= START_HEAD_Y;
            body   <= start_body();
        end else if (restart) begin
            head.x <= START_HEAD_X;  // Back to the start line
            head.y <= START_HEAD_Y;
            body   <= start_body();
        end else if (move) begin
            head <= step_head(head, heading);
            // Old head enters segment 0, the tail segment drops out
            body <= {body[BODY_SEGMENTS-2:0], head};
        end
    end

endmodule

`default_nettype wire

/* source/snake_game_top.sv */
// Snake game control core
`timescale 1ns/1ps
`default_nettype none

module snake_game_top
    import snake_pkg::*;
(
    input  wire        clock_25,
    input  wire        reset,
    input  wire        right_button,
    input  wire        left_button,
    input  wire        game_tick,
    output position_t  head,
    output heading_t   heading,
    output logic       playing,
    output logic       game_over
);

    logic  press;
    turn_t pending_turn;
    logic  restart;
    logic  move;     // One cycle per game step
    body_t body;

    turn_input turn_input_inst (
        .clock_25     (clock_25),
        .reset        (reset),
        .right_button (right_button),
        .left_button  (left_button),
        .restart      (restart),
        .move         (move),
        .playing      (playing),
        .press        (press),
        .pending_turn (pending_turn)
    );

    snake_body snake_body_inst (
        .clock_25 (clock_25),
        .reset    (reset),
        .restart  (restart),
        .move     (move),
        .heading  (heading),
        .head     (head),
        .body     (body)
    );

    game_control game_control_inst (
        .clock_25     (clock_25),
        .reset        (reset),
        .game_tick    (game_tick),
        .press        (press),
        .pending_turn (pending_turn),
        .head         (head),
        .body         (body),
        .heading      (heading),
        .restart      (restart),
        .move         (move),
        .playing      (playing),
        .game_over    (game_over)
    );

endmodule

`default_nettype wire

/* source/snake_pkg.sv */
// Snake game shared types
// Grid constants, coordinates and FSM encodings
`default_nettype none

package snake_pkg;

    // Board size in cells
    localparam int GRID_WIDTH  = 124;
    localparam int GRID_HEIGHT = 81;

    localparam int COORD_BITS    = 7;
    localparam int BODY_SEGMENTS = 5;  // Cells behind the head

    typedef logic [COORD_BITS-1:0] coord_t;

    // Start position, body trails to the left of the head
    localparam coord_t START_HEAD_X = 7'd8;
    localparam coord_t START_HEAD_Y = 7'd40;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } position_t;

    // Segment 0 sits next to the head
    typedef position_t [BODY_SEGMENTS-1:0] body_t;

    typedef struct packed {
        logic clockwise;
        logic counter_clockwise;
    } turn_t;

    typedef enum logic [1:0] {HEAD_UP, HEAD_DOWN, HEAD_LEFT, HEAD_RIGHT} heading_t;

    typedef enum logic [2:0] {
        RESTART,
        IDLE,
        WAIT_TICK,
        MOVING,
        MOVE_DONE,
        GAME_OVER
    } game_state_t;

endpackage

`default_nettype wire

/* source/turn_input.sv */
// Button conditioning and pending turn
`timescale 1ns/1ps
`default_nettype none

module turn_input
    import snake_pkg::*;
(
    input  wire   clock_25,
    input  wire   reset,
    input  wire   right_button,
    input  wire   left_button,
    input  wire   restart,
    input  wire   move,
    input  wire   playing,
    output logic  press,
    output turn_t pending_turn
);

    logic [1:0] right_shift;  // Sampled button history
    logic [1:0] left_shift;
    logic       right_edge;
    logic       left_edge;

    // Rising edge is taken once the level has passed the first stage
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            right_shift <= 2'b00;
            left_shift  <= 2'b00;
            right_edge  <= 1'b0;
            left_edge   <= 1'b0;
        end else begin
            right_shift <= {right_shift[0], right_button};
            left_shift  <= {left_shift[0], left_button};
            right_edge  <= right_shift[0] & ~right_shift[1];
            left_edge   <= left_shift[0] & ~left_shift[1];
        end
    end

    assign press = right_edge | left_edge;

    // Last press wins until the next move consumes it
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            pending_turn <= '0;
        end else if (restart) begin
            pending_turn <= '0;
        end else if (playing && press) begin
            // Both buttons together cancel the turn
            pending_turn.clockwise         <= right_edge & ~left_edge;
            pending_turn.counter_clockwise <= left_edge & ~right_edge;
        end else if (move) begin
            pending_turn <= '0;
        end
    end

endmodule

`default_nettype wire

/* verification/snake_game_checker.sv */
// Snake game assertions
`timescale 1ns/1ps
`default_nettype none

module snake_game_checker
    import snake_pkg::*;
(
    input wire            clock_25,
    input wire            reset,
    input wire            move,
    input wire            restart,
    input wire position_t head,
    input wire            playing,
    input wire            game_over
);

    // A game ends only out of a running game
    game_over_from_play: assert property (
        @(posedge clock_25) disable iff (!reset)
            $rose(game_over) |-> $past(playing)
    ) else $error("game_over rose outside a running game");

    head_in_grid: assert property (
        @(posedge clock_25) disable iff (!reset)
            (head.x < coord_t'(GRID_WIDTH)) && (head.y < coord_t'(GRID_HEIGHT))
    ) else $error("head left the grid");

    // Only a move step or a restart may change the head
    head_changes_on_move: assert property (
        @(posedge clock_25) disable iff (!reset)
            (!$past(move) && !$past(restart)) |-> $stable(head)
    ) else $error("head changed without a move");

endmodule

bind snake_game_top snake_game_checker snake_game_checker_inst (
    .clock_25  (clock_25),
    .reset     (reset),
    .move      (move),
    .restart   (restart),
    .head      (head),
    .playing   (playing),
    .game_over (game_over)
);

`default_nettype wire

/* verification/snake_game_tb.sv */
// Snake game testbench
`timescale 1ns/1ps
`default_nettype none

module snake_game_tb
    import snake_pkg::*;
();

    localparam int CLOCK_PERIOD  = 8;
    localparam int STIM_WORDS    = 7;   // Hex words per stim line
    localparam int MAX_LINES     = 64;
    localparam int SETTLE_CYCLES = 8;
    localparam int MARGIN_CYCLES = 100;

    logic      clock_25;
    logic      reset;
    logic      right_button;
    logic      left_button;
    logic      game_tick;
    position_t head;
    heading_t  heading;
    logic      playing;
    logic      game_over;

    logic [7:0] stim_mem [0:STIM_WORDS*MAX_LINES-1];
    int         errors;
    int         line_count;
    int         budget_cycles;
    bit         budget_ready;
    coord_t     model_x;  // Reference head, stepped along the expected heading
    coord_t     model_y;

    snake_game_top snake_game_top_inst (
        .clock_25     (clock_25),
        .reset        (reset),
        .right_button (right_button),
        .left_button  (left_button),
        .game_tick    (game_tick),
        .head         (head),
        .heading      (heading),
        .playing      (playing),
        .game_over    (game_over)
    );

    initial begin
        clock_25 = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock_25 = ~clock_25;
    end

    task automatic next_edge();
        @(posedge clock_25);
        #1;
    endtask

    task automatic settle();
        repeat (SETTLE_CYCLES) next_edge();
    endtask

    // Hold length must not matter to the press detector
    task automatic press_buttons(input logic right, input logic left);
        int hold;
        hold = $urandom_range(4, 1);
        next_edge();
        right_button = right;
        left_button  = left;
        repeat (hold) next_edge();
        right_button = 1'b0;
        left_button  = 1'b0;
        settle();
    endtask

    task automatic pulse_tick();
        next_edge();
        game_tick = 1'b1;
        next_edge();
        game_tick = 1'b0;
        settle();
    endtask

    // One cell along dir, a coordinate on the border is held
    task automatic step_model(input heading_t dir);
        case (dir)
            HEAD_UP: begin
                if (model_y != 7'd0)
                    model_y = model_y - 7'd1;
            end
            HEAD_DOWN: begin
                if (model_y != coord_t'(GRID_HEIGHT - 1))
                    model_y = model_y + 7'd1;
            end
            HEAD_LEFT: begin
                if (model_x != 7'd0)
                    model_x = model_x - 7'd1;
            end
            default: begin
                if (model_x != coord_t'(GRID_WIDTH - 1))
                    model_x = model_x + 7'd1;
            end
        endcase
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Watchdog, budget follows the stim lines and their tick counts
    initial begin
        wait (budget_ready);
        repeat (budget_cycles) @(posedge clock_25);
        $display("Timeout: the run did not finish within %0d cycles", budget_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        int         seed;
        int         base;
        int         line_index;
        int         repeats;
        logic [7:0] command;
        heading_t   last_heading;
        logic       last_playing;
        logic       last_game_over;

        errors       = 0;
        reset        = 1'b0;
        right_button = 1'b0;
        left_button  = 1'b0;
        game_tick    = 1'b0;
        seed         = $urandom(32'h2a8d);

        $readmemh("verification/snake_stim.txt", stim_mem);
        line_count    = 0;
        budget_cycles = MARGIN_CYCLES;
        while (line_count < MAX_LINES && stim_mem[line_count * STIM_WORDS] != 8'hff) begin
            budget_cycles += 16 + 12 * int'(stim_mem[line_count * STIM_WORDS + 1]);
            line_count++;
        end
        budget_ready = 1'b1;
        if (line_count == 0) begin
            $display("No stim lines were read from the stim file");
            errors++;
        end

        repeat (4) @(posedge clock_25);
        #1;
        reset = 1'b1;
        next_edge();  // RESTART to IDLE

        model_x        = START_HEAD_X;
        model_y        = START_HEAD_Y;
        last_heading   = HEAD_RIGHT;
        last_playing   = 1'b0;
        last_game_over = 1'b0;

        for (line_index = 0; line_index < line_count; line_index++) begin
            base    = line_index * STIM_WORDS;
            command = stim_mem[base];
            repeats = int'(stim_mem[base + 1]);
            case (command)
                8'h00: settle();
                8'h01, 8'h02, 8'h03: begin
                    press_buttons(command[0], command[1]);
                    if (last_game_over) begin  // Press after game over restarts
                        model_x = START_HEAD_X;
                        model_y = START_HEAD_Y;
                    end
                end
                8'h04: begin
                    repeat (repeats) begin
                        pulse_tick();
                        if (last_playing)
                            step_model(last_heading);
                    end
                end
                default: begin
                    $display("Stim line %0d has an unknown command %0h", line_index + 1, command);
                    errors++;
                end
            endcase

            compare_value("head.x", int'(stim_mem[base + 2]), int'(head.x));
            compare_value("head.y", int'(stim_mem[base + 3]), int'(head.y));
            compare_value("heading", int'(stim_mem[base + 4][1:0]), int'(heading));
            compare_value("playing", int'(stim_mem[base + 5][0]), int'(playing));
            compare_value("game_over", int'(stim_mem[base + 6][0]), int'(game_over));
            compare_value("head.x against model", int'(model_x), int'(head.x));
            compare_value("head.y against model", int'(model_y), int'(head.y));

            last_heading   = heading_t'(stim_mem[base + 4][1:0]);
            last_playing   = stim_mem[base + 5][0];
            last_game_over = stim_mem[base + 6][0];
        end

        $display("Run finished: %0d stim lines, %0d errors", line_count, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/snake_stim.txt */
// cmd count x y heading playing game_over, all hex
// cmd 0 check, 1 right, 2 left, 3 both, 4 tick; heading 0 up, 1 down, 2 left, 3 right
00 00 08 28 3 0 0  // after reset
04 02 08 28 3 0 0  // ticks in idle
01 00 08 28 3 1 0  // start, no turn
04 03 0b 28 3 1 0
01 00 0b 28 1 1 0  // clockwise to down
04 01 0b 29 1 1 0
02 00 0b 29 3 1 0  // counter-clockwise to right
04 01 0c 29 3 1 0
03 00 0c 29 3 1 0  // both buttons, no turn
01 00 0c 29 1 1 0  // square onto the body
04 01 0c 2a 1 1 0
01 00 0c 2a 2 1 0
04 01 0b 2a 2 1 0
01 00 0b 2a 0 1 0
04 01 0b 29 0 0 1  // head on body segment 3
04 02 0b 29 0 0 1  // frozen
02 00 08 28 3 0 0  // restart
02 00 08 28 3 1 0
02 00 08 28 0 1 0  // up
04 28 08 00 0 0 1  // top border
04 01 08 00 0 0 1
01 00 08 28 3 0 0
01 00 08 28 3 1 0
04 01 09 28 3 1 0
ff 00 00 00 0 0 0  // end of stim
